/* verilog/alu_pkg.sv */
package alu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path widths

	// One operand or one result
	typedef logic [15:0] data_t;

	typedef logic [3:0]  op_t;

	// Queued operation: opcode [35:32], operand a [31:16], operand b [15:0]
	typedef logic [35:0] entry_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes

	localparam op_t OP_ADD   = 4'd0;
	localparam op_t OP_AND   = 4'd1;
	localparam op_t OP_OR    = 4'd2;
	localparam op_t OP_SLL   = 4'd3;
	localparam op_t OP_SRL   = 4'd4;
	localparam op_t OP_SRA   = 4'd5;
	localparam op_t OP_SUB   = 4'd6;
	localparam op_t OP_EQUAL = 4'd7;
	localparam op_t OP_LESS  = 4'd8;
	localparam op_t OP_MOVE  = 4'd9;
	// Codes 10 to 14 are unassigned
	localparam op_t OP_EMPTY = 4'd15;

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM states

	typedef enum logic [1:0] {ISSUE_IDLE, ISSUE_ACK, ISSUE_WAIT_LOW} issue_state_e;

	typedef enum logic [1:0] {EXEC_IDLE, EXEC_REQ, EXEC_WAIT_LOW} exec_state_e;

endpackage

/* verilog/queue_if.sv */
`timescale 1ns/1ns

// Operation queue link between issue and execute
interface queue_if
	import alu_pkg::*;
();

	// Write side
	logic   push_stb;
	entry_t push_entry;
	logic   full;

	// Read side, pop_entry is the oldest entry
	logic   pop_stb;
	entry_t pop_entry;
	logic   empty;

	modport push (
		output push_stb,
		output push_entry,
		input  full
	);

	modport pop (
		output pop_stb,
		input  pop_entry,
		input  empty
	);

	modport queue (
		input  push_stb,
		input  push_entry,
		output full,
		input  pop_stb,
		output pop_entry,
		output empty
	);

endinterface

/* verilog/op_issue.sv */
`timescale 1ns/1ns

module op_issue
	import alu_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  cmd_req,
	output logic  cmd_ack,
	input  op_t   cmd_op,
	input  data_t cmd_a,
	input  data_t cmd_b,
	queue_if.push q
);

	issue_state_e state;
	issue_state_e state_next;
	logic         accept;

	// Take a command only while there is room for it
	assign accept = (state == ISSUE_IDLE) && cmd_req && !q.full;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase command handshake

	always_comb begin
		state_next = state;
		case (state)
			ISSUE_IDLE: begin
				if (accept) begin
					state_next = ISSUE_ACK;
				end
			end
			ISSUE_ACK: begin
				// Ack held until the client drops req
				if (!cmd_req) begin
					state_next = ISSUE_WAIT_LOW;
				end
			end
			ISSUE_WAIT_LOW: begin
				// One quiet sample of req before re-arming
				if (!cmd_req) begin
					state_next = ISSUE_IDLE;
				end
			end
			default: state_next = ISSUE_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ISSUE_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign cmd_ack = (state == ISSUE_ACK);

	// Entry written at the same edge that raises cmd_ack
	assign q.push_stb   = accept;
	assign q.push_entry = {cmd_op, cmd_a, cmd_b};

endmodule

/* verilog/op_queue.sv */
`timescale 1ns/1ns

module op_queue
	import alu_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)(
	input  logic   clk,
	input  logic   arst_n,
	queue_if.queue q
);

	// Depth is a power of two, so pointers wrap on their own
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	entry_t           mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = q.push_stb && !q.full;
	assign do_pop  = q.pop_stb && !q.empty;

	////////////////////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= q.push_entry;
		end
	end

	assign q.pop_entry = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign q.full  = (count == CNT_W'(QUEUE_DEPTH));
	assign q.empty = (count == '0);

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu
	import alu_pkg::*;
(
	input  op_t   op,
	input  data_t a,
	input  data_t b,
	output data_t result
);

	logic       shift_over;
	logic [3:0] sra_amt;

	// Any bit above 15 means the whole value shifts out
	assign shift_over = |b[15:4];

	// Shifting by 15 already replicates the sign into every bit
	assign sra_amt = shift_over ? 4'd15 : b[3:0];

	always_comb begin
		case (op)
			OP_ADD: result = a + b;
			OP_SUB: result = a - b;
			OP_AND: result = a & b;
			OP_OR:  result = a | b;
			OP_SLL: begin
				result = shift_over ? '0 : a << b[3:0];
			end
			OP_SRL: begin
				result = shift_over ? '0 : a >> b[3:0];
			end
			OP_SRA: begin
				// True arithmetic shift with sign fill
				result = data_t'($signed(a) >>> sra_amt);
			end
			OP_EQUAL: result = data_t'(a == b);
			// Unsigned compare
			OP_LESS:  result = data_t'(a < b);
			OP_MOVE:  result = a;
			OP_EMPTY: result = '0;
			// Unassigned codes
			default:  result = '0;
		endcase
	end

endmodule

/* verilog/alu_exec.sv */
`timescale 1ns/1ns

module alu_exec
	import alu_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	queue_if.pop  q,
	output logic  res_req,
	input  logic  res_ack,
	output data_t res_data
);

	exec_state_e state;
	exec_state_e state_next;
	op_t         op;
	data_t       a;
	data_t       b;
	data_t       alu_result;

	////////////////////////////////////////////////////////////////////////////
	// Oldest entry into the ALU

	assign op = q.pop_entry[35:32];
	assign a  = q.pop_entry[31:16];
	assign b  = q.pop_entry[15:0];

	alu alu_inst (
		.op     (op),
		.a      (a),
		.b      (b),
		.result (alu_result)
	);

	// Next entry only once the previous result handshake has closed
	assign q.pop_stb = (state == EXEC_IDLE) && !q.empty;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase result handshake

	always_comb begin
		state_next = state;
		case (state)
			EXEC_IDLE: begin
				if (q.pop_stb) begin
					state_next = EXEC_REQ;
				end
			end
			EXEC_REQ: begin
				if (res_ack) begin
					state_next = EXEC_WAIT_LOW;
				end
			end
			EXEC_WAIT_LOW: begin
				if (!res_ack) begin
					state_next = EXEC_IDLE;
				end
			end
			default: state_next = EXEC_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= EXEC_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Result captured on the pop edge, stable through the handshake
	always_ff @(posedge clk) begin
		if (q.pop_stb) begin
			res_data <= alu_result;
		end
	end

	assign res_req = (state == EXEC_REQ);

endmodule

/* verilog/alu_top.sv */
`timescale 1ns/1ns

module alu_top
	import alu_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)(
	input  logic  clk,
	input  logic  arst_n,
	// Command port
	input  logic  cmd_req,
	output logic  cmd_ack,
	input  op_t   cmd_op,
	input  data_t cmd_a,
	input  data_t cmd_b,
	// Result port
	output logic  res_req,
	input  logic  res_ack,
	output data_t res_data
);

	queue_if q_if ();

	op_issue issue_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.cmd_req (cmd_req),
		.cmd_ack (cmd_ack),
		.cmd_op  (cmd_op),
		.cmd_a   (cmd_a),
		.cmd_b   (cmd_b),
		.q       (q_if.push)
	);

	op_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.q      (q_if.queue)
	);

	alu_exec exec_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.q        (q_if.pop),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

endmodule

/* dv/alu_props.sv */
`timescale 1ns/1ns

module alu_props
	import alu_pkg::*;
(
	input logic  clk,
	input logic  arst_n,
	input logic  cmd_req,
	input logic  cmd_ack,
	input logic  res_req,
	input logic  res_ack,
	input data_t res_data
);

	// Ack only answers a pending request
	ack_after_req: assert property (
		@(posedge clk) disable iff (!arst_n) $rose(cmd_ack) |-> cmd_req
	) else $error("cmd_ack rose while cmd_req was low");

	res_req_held: assert property (
		@(posedge clk) disable iff (!arst_n) res_req && !res_ack |=> res_req
	) else $error("res_req dropped before res_ack was seen");

	res_data_held: assert property (
		@(posedge clk) disable iff (!arst_n) res_req && !res_ack |=> $stable(res_data)
	) else $error("res_data changed while waiting for res_ack");

	quiet_in_reset: assert property (
		@(posedge clk) !arst_n |-> !cmd_ack && !res_req
	) else $error("handshake output active during reset");

endmodule

bind alu_top alu_props props_inst (
	.clk      (clk),
	.arst_n   (arst_n),
	.cmd_req  (cmd_req),
	.cmd_ack  (cmd_ack),
	.res_req  (res_req),
	.res_ack  (res_ack),
	.res_data (res_data)
);

/* dv/alu_tb.sv */
`timescale 1ns/1ns

module alu_tb
	import alu_pkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	// About 300 operations over all tests at under 12 cycles each, with margin
	localparam int MAX_CYCLES  = 5000;

	logic  clk;
	logic  arst_n;
	logic  cmd_req;
	logic  cmd_ack;
	op_t   cmd_op;
	data_t cmd_a;
	data_t cmd_b;
	logic  res_req;
	logic  res_ack;
	data_t res_data;

	// Operations of the current test, in command order
	op_t    op_q[$];
	data_t  a_q[$];
	data_t  b_q[$];
	data_t  exp_q[$];
	int     delay_q[$];

	integer seed;
	int     cycle_count;
	int     test_count;
	int     check_count;
	int     error_count;
	int     test_errors;
	int     sent_count;
	int     recv_count;
	string  test_name;
	logic   hold_check;
	logic   res_req_prev;

	alu_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) alu_top_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.cmd_req  (cmd_req),
		.cmd_ack  (cmd_ack),
		.cmd_op   (cmd_op),
		.cmd_a    (cmd_a),
		.cmd_b    (cmd_b),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Every result the DUT offers, counted at the rise of res_req
	always @(posedge clk) begin
		res_req_prev <= res_req;
		if (res_req && !res_req_prev) begin
			recv_count++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model of the operation set

	function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
		logic [31:0] zero_ext;
		logic [31:0] sign_ext;
		int          amt;
		data_t       r;
		// Shift counts of 16 and up all behave like 16
		amt      = (b >= 16'd16) ? 16 : int'(b);
		zero_ext = {16'd0, a};
		sign_ext = {{16{a[15]}}, a};
		case (op)
			OP_ADD:   r = a + b;
			OP_SUB:   r = a - b;
			OP_AND:   r = a & b;
			OP_OR:    r = a | b;
			OP_SLL:   r = data_t'(zero_ext << amt);
			OP_SRL:   r = data_t'(zero_ext >> amt);
			OP_SRA:   r = data_t'(sign_ext >> amt);
			OP_EQUAL: r = (a == b) ? 16'd1 : 16'd0;
			OP_LESS:  r = (a < b) ? 16'd1 : 16'd0;
			OP_MOVE:  r = a;
			default:  r = 16'd0;
		endcase
		return r;
	endfunction

	task automatic add_op(input op_t op, input data_t a, input data_t b, input int delay);
		op_q.push_back(op);
		a_q.push_back(a);
		b_q.push_back(b);
		exp_q.push_back(model_result(op, a, b));
		delay_q.push_back(delay);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Client side of both ports

	task automatic send_cmd(input op_t op, input data_t a, input data_t b);
		cmd_op  <= op;
		cmd_a   <= a;
		cmd_b   <= b;
		cmd_req <= 1'b1;
		do begin
			@(posedge clk);
		end while (!cmd_ack);
		cmd_req <= 1'b0;
		sent_count++;
		do begin
			@(posedge clk);
		end while (cmd_ack);
	endtask

	task automatic send_all();
		for (int i = 0; i < op_q.size(); i++) begin
			send_cmd(op_q[i], a_q[i], b_q[i]);
		end
	endtask

	task automatic collect_results(input int n);
		data_t got;
		for (int i = 0; i < n; i++) begin
			do begin
				@(posedge clk);
			end while (!res_req);
			got = res_data;
			check_count++;
			assert (got == exp_q[i]) else begin
				$display("Mismatch in %s: result %0d expected %h actual %h",
					test_name, i, exp_q[i], got);
				test_errors++;
			end
			repeat (delay_q[i]) @(posedge clk);
			// Held result plus a full queue
			if (hold_check && i == 0) begin
				check_count++;
				assert (sent_count == QUEUE_DEPTH + 1) else begin
					$display("Mismatch in %s: accepted while held expected %0d actual %0d",
						test_name, QUEUE_DEPTH + 1, sent_count);
					test_errors++;
				end
			end
			res_ack <= 1'b1;
			do begin
				@(posedge clk);
			end while (res_req);
			res_ack <= 1'b0;
		end
	endtask

	task automatic run_test(input string name);
		test_name   = name;
		test_errors = 0;
		sent_count  = 0;
		recv_count  = 0;
		fork
			send_all();
			collect_results(op_q.size());
		join
		// A surplus result would rise within this quiet period
		repeat (4) @(posedge clk);
		check_count++;
		assert (sent_count == recv_count) else begin
			$display("Mismatch in %s: results expected %0d actual %0d",
				name, sent_count, recv_count);
			test_errors++;
		end
		$display("Test %s: %0d operations, %0d errors", name, recv_count, test_errors);
		error_count += test_errors;
		test_count++;
		hold_check = 1'b0;
		op_q.delete();
		a_q.delete();
		b_q.delete();
		exp_q.delete();
		delay_q.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus builders

	task automatic build_shift_ops();
		op_t   ops[3];
		data_t amounts[4];
		ops     = '{OP_SLL, OP_SRL, OP_SRA};
		amounts = '{16'd0, 16'd15, 16'd16, 16'd40};
		foreach (ops[i]) begin
			foreach (amounts[j]) begin
				add_op(ops[i], 16'hb6c5, amounts[j], 0);
			end
		end
		// Positive value, zero fill on SRA
		foreach (amounts[j]) begin
			add_op(OP_SRA, 16'h7a3c, amounts[j], 1);
		end
	endtask

	task automatic build_random_ops(input int n);
		logic [31:0] r_op;
		logic [31:0] r_a;
		logic [31:0] r_b;
		data_t       b;
		for (int i = 0; i < n; i++) begin
			r_op = $random(seed);
			r_a  = $random(seed);
			r_b  = $random(seed);
			b    = r_b[15:0];
			// Small counts half the time so shifts keep some bits
			if (r_b[31]) begin
				b = {10'd0, r_b[5:0]};
			end
			add_op(r_op[3:0], r_a[15:0], b, int'(r_op[9:8]));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	initial begin : main
		seed        = 32'hbb9d_6397;
		test_count  = 0;
		check_count = 0;
		error_count = 0;
		hold_check  = 1'b0;
		arst_n      = 1'b0;
		cmd_req     = 1'b0;
		cmd_op      = OP_ADD;
		cmd_a       = '0;
		cmd_b       = '0;
		res_ack     = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		add_op(OP_ADD, 16'h1234, 16'h0101, 0);
		add_op(OP_ADD, 16'hfff0, 16'h0025, 1);
		add_op(OP_SUB, 16'h0500, 16'h0123, 0);
		add_op(OP_SUB, 16'h0003, 16'h0010, 2);
		add_op(OP_AND, 16'hf0f0, 16'h3c3c, 0);
		add_op(OP_OR,  16'hf000, 16'h00a5, 0);
		add_op(OP_SLL, 16'h00f1, 16'h0004, 1);
		add_op(OP_SRL, 16'hf100, 16'h0004, 0);
		add_op(OP_SRA, 16'h8040, 16'h0003, 0);
		add_op(OP_EQUAL, 16'h55aa, 16'h55aa, 3);
		add_op(OP_LESS, 16'h0010, 16'h0020, 0);
		add_op(OP_MOVE, 16'hbeef, 16'h1111, 0);
		run_test("directed_ops");

		build_shift_ops();
		run_test("shift_edges");

		add_op(OP_EQUAL, 16'h0005, 16'h0005, 0);
		add_op(OP_EQUAL, 16'h0005, 16'h0006, 0);
		add_op(OP_EQUAL, 16'h0006, 16'h0005, 1);
		add_op(OP_LESS, 16'h0005, 16'h0005, 0);
		add_op(OP_LESS, 16'h0005, 16'h0006, 0);
		add_op(OP_LESS, 16'h0006, 16'h0005, 2);
		// Unsigned, so 0xffff is the largest value
		add_op(OP_LESS, 16'hffff, 16'h0001, 0);
		add_op(OP_LESS, 16'h0001, 16'hffff, 0);
		for (int c = 10; c < 16; c++) begin
			add_op(op_t'(c), 16'ha5a5, 16'h0f0f, 0);
		end
		run_test("compare_undef");

		hold_check = 1'b1;
		for (int i = 0; i < 8; i++) begin
			add_op(OP_ADD, 16'h0100 * data_t'(i), 16'h0011, (i == 0) ? 40 : 0);
		end
		run_test("backpressure");

		build_random_ops(250);
		run_test("random_stream");

		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

/* filelist.f */
verilog/alu_pkg.sv
verilog/queue_if.sv
verilog/op_issue.sv
verilog/op_queue.sv
verilog/alu.sv
verilog/alu_exec.sv
verilog/alu_top.sv
dv/alu_props.sv
dv/alu_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module alu_tb

# An aborted run counts as a failure in the log
sim:
	verilator --binary --timing --assert -f filelist.f --top-module alu_tb -o alu_sim
	./obj_dir/alu_sim > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
